/* dv/snoop_unit_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module snoop_unit_sva import snoop_pkg::*; (
    input wire logic                 clk_i,
    input wire logic                 rst_ni,
    input wire logic                 su_ready_o,
    input wire logic [NUM_PORTS-1:0] cd_ready_o,
    input wire r_beat_t              r_o,
    input wire logic                 r_valid_o,
    input wire logic                 r_ready_i,
    input wire logic                 cd_busy_o,
    input wire logic                 cd_done_o
);

    // R beat is held while the sink stalls
    r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o))
        else $error("r_o changed or dropped while stalled");

    // Every CD port is drained by the time done fires
    done_in_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cd_done_o |-> cd_busy_o && (cd_ready_o == '0))
        else $error("cd_done_o outside a busy transaction or with CD ports still open");

    no_cmd_when_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cd_busy_o |-> !su_ready_o)
        else $error("su_ready_o high while busy");

endmodule

bind snoop_unit_top snoop_unit_sva sva0 (.*);

`default_nettype wire

/* dv/snoop_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module snoop_unit_tb import snoop_pkg::*; ();

    localparam int CLK_PERIOD  = 20;
    localparam int NUM_ROWS    = 10;
    localparam int ROW_TIMEOUT = 400;  // Cycles per row

    // One stimulus row with its expected line data
    typedef struct packed {
        su_op_e                            op;
        logic [ID_W-1:0]                   id;
        logic                              single_beat;
        logic [BEAT_IDX_W-1:0]             beat_offset;
        logic                              shared;
        logic                              dirty;
        logic [NUM_PORTS-1:0]              mask;
        logic [PORT_IDX_W-1:0]             first;
        logic [LINE_BEATS-1:0][DATA_W-1:0] line;
        logic [31:0]                       stall_pct;
    } row_t;

    logic                     clk_i;
    logic                     rst_ni;
    snoop_cmd_t               su_cmd_i;
    logic                     su_valid_i;
    logic                     su_ready_o;
    cd_beat_t [NUM_PORTS-1:0] cd_i;
    logic [NUM_PORTS-1:0]     cd_valid_i;
    logic [NUM_PORTS-1:0]     cd_ready_o;
    r_beat_t                  r_o;
    logic                     r_valid_o;
    logic                     r_ready_i;
    logic                     cd_busy_o;
    logic                     cd_done_o;

    row_t                 rows [NUM_ROWS];
    row_t                 cur;
    snoop_cmd_t           cmd_cur;
    r_beat_t              r_seen [$];
    logic [NUM_PORTS-1:0] mask_cur;
    logic [NUM_PORTS-1:0] took;          // CD handshake seen at the last rising edge
    int                   cd_beat [NUM_PORTS];
    int                   cd_wait [NUM_PORTS];
    logic                 cmd_pending;
    logic                 accepted;
    int                   done_cnt;
    int                   wait_cnt;
    int                   check_errs;
    int                   timeout_errs;
    int                   seed;

    snoop_unit_top dut0 (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .su_cmd_i   (su_cmd_i),
        .su_valid_i (su_valid_i),
        .su_ready_o (su_ready_o),
        .cd_i       (cd_i),
        .cd_valid_i (cd_valid_i),
        .cd_ready_o (cd_ready_o),
        .r_o        (r_o),
        .r_valid_o  (r_valid_o),
        .r_ready_i  (r_ready_i),
        .cd_busy_o  (cd_busy_o),
        .cd_done_o  (cd_done_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    function automatic row_t make_row(input su_op_e op, input logic [ID_W-1:0] id,
                                      input logic single, input logic [BEAT_IDX_W-1:0] off,
                                      input logic shared, input logic dirty,
                                      input logic [NUM_PORTS-1:0] mask,
                                      input logic [PORT_IDX_W-1:0] first,
                                      input logic [31:0] base, input int stall);
        row_t r;
        r = '0;
        r.op          = op;
        r.id          = id;
        r.single_beat = single;
        r.beat_offset = off;
        r.shared      = shared;
        r.dirty       = dirty;
        r.mask        = mask;
        r.first       = first;
        r.stall_pct   = stall;
        for (int b = 0; b < LINE_BEATS; b++) begin
            r.line[b] = {base, 24'h0, 8'(b)};
        end
        return r;
    endfunction

    // Other ports carry data that must never reach R
    function automatic logic [DATA_W-1:0] cd_word(input int port, input int beat);
        if (port == int'(cur.first)) begin
            return cur.line[beat];
        end
        return ~cur.line[beat] ^ DATA_W'(port);
    endfunction

    task automatic check_value(input string what, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
            check_errs++;
        end
    endtask

    task automatic drive_cd();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (took[p]) begin
                took[p]       = 1'b0;
                cd_valid_i[p] = 1'b0;
                cd_beat[p]++;
                cd_wait[p]    = {$random(seed)} % 4;
            end
            if (mask_cur[p] && !cd_valid_i[p] && cd_beat[p] < LINE_BEATS) begin
                if (cd_wait[p] == 0) begin
                    cd_valid_i[p] = 1'b1;
                    cd_i[p].data  = cd_word(p, cd_beat[p]);
                    cd_i[p].last  = (cd_beat[p] == LINE_BEATS - 1);
                end else begin
                    cd_wait[p]--;
                end
            end
        end
    endtask

    task automatic sample_outputs();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (cd_valid_i[p] && cd_ready_o[p]) took[p] = 1'b1;
        end
        check_value("cd_ready_o outside mask", DATA_W'(cd_ready_o & ~mask_cur), '0);
        if (accepted) begin
            check_value("su_ready_o before the response ends", DATA_W'(su_ready_o), '0);
        end
        if (cd_done_o) begin
            check_value("cd_done_o without a read in flight",
                        DATA_W'(accepted && cur.op == READ_SNP_DATA), DATA_W'(1));
            done_cnt++;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (mask_cur[p]) begin
                    check_value($sformatf("port %0d beats before done", p),
                                DATA_W'(cd_beat[p]), DATA_W'(LINE_BEATS));
                end
            end
        end
        if (su_valid_i && su_ready_o) begin
            cmd_pending = 1'b0;
            accepted    = 1'b1;
        end
        if (r_valid_o && r_ready_i) r_seen.push_back(r_o);
    endtask

    // Drive on the falling edge, sample on the rising edge
    task automatic run_cycle();
        @(negedge clk_i);
        if (cmd_pending) su_cmd_i = cmd_cur;
        su_valid_i = cmd_pending;
        r_ready_i  = ({$random(seed)} % 100) >= cur.stall_pct;
        drive_cd();
        @(posedge clk_i);
        sample_outputs();
    endtask

    task automatic start_row(input int idx);
        cur      = rows[idx];
        mask_cur = (cur.op == READ_SNP_DATA) ? cur.mask : '0;
        cmd_cur.op              = cur.op;
        cmd_cur.id              = cur.id;
        cmd_cur.single_beat     = cur.single_beat;
        cmd_cur.beat_offset     = cur.beat_offset;
        cmd_cur.shared          = cur.shared;
        cmd_cur.dirty           = cur.dirty;
        cmd_cur.data_available  = cur.mask;
        cmd_cur.first_responder = cur.first;
        for (int p = 0; p < NUM_PORTS; p++) begin
            cd_beat[p] = 0;
            cd_wait[p] = {$random(seed)} % 4;
        end
        r_seen.delete();
        done_cnt    = 0;
        accepted    = 1'b0;
        cmd_pending = 1'b1;
    endtask

    function automatic logic row_done();
        if (cur.op == READ_SNP_DATA) return done_cnt > 0;
        return accepted && r_seen.size() > 0;
    endfunction

    task automatic check_row(input int idx);
        int                n_exp;
        logic [DATA_W-1:0] exp_data;
        logic [3:0]        exp_resp;
        logic              exp_last;
        n_exp = (cur.op == READ_SNP_DATA && !cur.single_beat) ? LINE_BEATS : 1;
        check_value($sformatf("row %0d beat count", idx), DATA_W'(r_seen.size()),
                    DATA_W'(n_exp));
        for (int b = 0; b < r_seen.size() && b < n_exp; b++) begin
            if (cur.op == SEND_INVALID_ACK_R) begin
                exp_data = '0;
                exp_resp = 4'b0000;
                exp_last = 1'b1;
            end else begin
                exp_data = cur.single_beat ? cur.line[cur.beat_offset] : cur.line[b];
                exp_resp = {cur.shared, cur.dirty, 2'b00};
                exp_last = cur.single_beat || (b == LINE_BEATS - 1);
            end
            check_value($sformatf("row %0d beat %0d id", idx, b), DATA_W'(r_seen[b].id),
                        DATA_W'(cur.id));
            check_value($sformatf("row %0d beat %0d data", idx, b), r_seen[b].data, exp_data);
            check_value($sformatf("row %0d beat %0d resp", idx, b), DATA_W'(r_seen[b].resp),
                        DATA_W'(exp_resp));
            check_value($sformatf("row %0d beat %0d last", idx, b), DATA_W'(r_seen[b].last),
                        DATA_W'(exp_last));
        end
    endtask

    initial begin
        rst_ni       = 1'b0;
        su_cmd_i     = '0;
        su_valid_i   = 1'b0;
        cd_i         = '0;
        cd_valid_i   = '0;
        r_ready_i    = 1'b0;
        seed         = 77;
        check_errs   = 0;
        timeout_errs = 0;
        cur          = '0;
        cmd_cur      = '0;
        mask_cur     = '0;
        took         = '0;
        cmd_pending  = 1'b0;

        //                op                  id     sgl   off   sh    dt    mask     fr
        rows[0] = make_row(SEND_INVALID_ACK_R, 4'h1, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000, 2'd0,
                           32'h0, 0);
        rows[1] = make_row(SEND_INVALID_ACK_R, 4'h2, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000, 2'd0,
                           32'h0, 90);
        rows[2] = make_row(READ_SNP_DATA, 4'h3, 1'b0, 1'b0, 1'b1, 1'b0, 4'b0001, 2'd0,
                           32'ha0a0_0001, 0);
        rows[3] = make_row(READ_SNP_DATA, 4'h4, 1'b1, 1'b0, 1'b0, 1'b1, 4'b0010, 2'd1,
                           32'hb1b1_0002, 30);
        rows[4] = make_row(READ_SNP_DATA, 4'h5, 1'b1, 1'b1, 1'b1, 1'b1, 4'b0100, 2'd2,
                           32'hc2c2_0003, 30);
        rows[5] = make_row(READ_SNP_DATA, 4'h6, 1'b0, 1'b0, 1'b0, 1'b0, 4'b1011, 2'd3,
                           32'hd3d3_0004, 20);
        rows[6] = make_row(READ_SNP_DATA, 4'h7, 1'b0, 1'b0, 1'b1, 1'b0, 4'b0110, 2'd2,
                           32'he4e4_0005, 85);  // Heavy R back-pressure
        rows[7] = make_row(READ_SNP_DATA, 4'h8, 1'b1, 1'b1, 1'b0, 1'b0, 4'b1111, 2'd0,
                           32'hf5f5_0006, 50);
        rows[8] = make_row(SEND_INVALID_ACK_R, 4'h9, 1'b0, 1'b0, 1'b1, 1'b1, 4'b0000, 2'd0,
                           32'h0, 40);
        rows[9] = make_row(READ_SNP_DATA, 4'ha, 1'b0, 1'b0, 1'b1, 1'b1, 4'b1101, 2'd2,
                           32'h1717_0007, 60);

        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        check_value("su_ready_o in reset", DATA_W'(su_ready_o), DATA_W'(1));
        check_value("outputs in reset", DATA_W'({r_valid_o, cd_ready_o, cd_busy_o, cd_done_o}),
                    '0);
        rst_ni = 1'b1;
        @(posedge clk_i);

        for (int i = 0; i < NUM_ROWS; i++) begin
            start_row(i);
            wait_cnt = 0;
            while (!row_done() && wait_cnt < ROW_TIMEOUT) begin
                run_cycle();
                wait_cnt++;
            end
            if (!row_done()) begin
                $display("Timeout: row %0d did not finish within %0d cycles", i, ROW_TIMEOUT);
                timeout_errs++;
                break;
            end
            check_row(i);
        end

        $display("Check errors: %0d, timeouts: %0d", check_errs, timeout_errs);
        if (check_errs == 0 && timeout_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the snoop unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module snoop_unit_tb -f sim.f

out=$(./obj_dir/Vsnoop_unit_tb) || true
echo "$out"
echo "$out" | grep -qx "sim passed"

/* sim.f */
verilog/snoop_pkg.sv
verilog/snoop_data_fifo.sv
verilog/cd_collector.sv
verilog/beat_counter.sv
verilog/snoop_resp_fsm.sv
verilog/snoop_unit_top.sv
dv/snoop_unit_sva.sv
dv/snoop_unit_tb.sv

/* verilog/beat_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module beat_counter import snoop_pkg::*; (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  clear_i,
    input  wire logic                  incr_i,
    output logic      [BEAT_IDX_W-1:0] beat_idx_o
);

    logic [BEAT_IDX_W-1:0] beat_q;

    // Counts every pop, skipped beats included
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            beat_q <= '0;
        end else if (clear_i) begin
            beat_q <= '0;
        end else if (incr_i) begin
            if (beat_q == BEAT_IDX_W'(LINE_BEATS - 1)) begin
                beat_q <= '0;  // Wrap at line end
            end else begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    assign beat_idx_o = beat_q;

endmodule

`default_nettype wire

/* verilog/cd_collector.sv */
`timescale 1ns/1ps
`default_nettype none

module cd_collector import snoop_pkg::*; (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  busy_i,
    input  wire logic [NUM_PORTS-1:0]  data_available_i,
    input  wire logic [PORT_IDX_W-1:0] first_responder_i,
    input  wire logic                  fifo_full_i,
    input  wire cd_beat_t [NUM_PORTS-1:0] cd_i,
    input  wire logic [NUM_PORTS-1:0]  cd_valid_i,
    output logic      [NUM_PORTS-1:0]  cd_ready_o,
    output logic                       push_o,
    output logic      [DATA_W-1:0]     push_data_o,
    output logic                       all_last_o
);

    logic [NUM_PORTS-1:0] last_seen_q;
    logic [NUM_PORTS-1:0] last_seen_d;
    logic                 all_last_q;

    // Ready per port; other responders are drained and their data dropped
    always_comb begin
        cd_ready_o = '0;
        if (busy_i) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                cd_ready_o[i] = data_available_i[i] && !last_seen_q[i];
            end
            if (fifo_full_i) begin
                cd_ready_o[first_responder_i] = 1'b0;  // Hold off until FIFO drains
            end
        end
    end

    always_comb begin
        last_seen_d = last_seen_q;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (cd_valid_i[i] && cd_ready_o[i] && cd_i[i].last) begin
                last_seen_d[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            last_seen_q <= '0;
            all_last_q  <= 1'b0;
        end else if (!busy_i) begin
            last_seen_q <= '0;
            all_last_q  <= 1'b0;
        end else begin
            last_seen_q <= last_seen_d;
            all_last_q  <= (last_seen_d == data_available_i);
        end
    end

    assign push_o      = cd_valid_i[first_responder_i] && cd_ready_o[first_responder_i];
    assign push_data_o = cd_i[first_responder_i].data;
    assign all_last_o  = all_last_q;

endmodule

`default_nettype wire

/* verilog/snoop_data_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module snoop_data_fifo import snoop_pkg::*; (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,
    input  wire logic              flush_i,
    input  wire logic              push_i,
    input  wire logic              pop_i,
    input  wire logic [DATA_W-1:0] data_i,
    output logic      [DATA_W-1:0] data_o,
    output logic                   full_o,
    output logic                   empty_o
);

    logic [DATA_W-1:0]     mem_q [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr_q;
    logic [FIFO_PTR_W-1:0] rd_ptr_q;
    logic [FIFO_CNT_W-1:0] count_q;
    logic                  do_push;
    logic                  do_pop;

    function automatic logic [FIFO_PTR_W-1:0] ptr_inc(input logic [FIFO_PTR_W-1:0] ptr);
        if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
    assign empty_o = (count_q == '0);
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign data_o  = mem_q[rd_ptr_q];  // No fall-through

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (do_pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
            count_q <= count_q + FIFO_CNT_W'(do_push) - FIFO_CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push && !flush_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

`default_nettype wire

/* verilog/snoop_pkg.sv */
`default_nettype none

package snoop_pkg;

    localparam int NUM_PORTS  = 4;
    localparam int DATA_W     = 64;
    localparam int LINE_BEATS = 2;  // 4 works as well
    localparam int BEAT_IDX_W = (LINE_BEATS > 1) ? $clog2(LINE_BEATS) : 1;
    localparam int PORT_IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
    localparam int ID_W       = 4;

    // Data buffer sizing
    localparam int FIFO_DEPTH = 2;
    localparam int FIFO_PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef enum logic {
        SEND_INVALID_ACK_R,
        READ_SNP_DATA
    } su_op_e;

    typedef struct packed {
        su_op_e                  op;
        logic [ID_W-1:0]         id;
        logic                    single_beat;     // 0 for a full line
        logic [BEAT_IDX_W-1:0]   beat_offset;
        logic                    shared;
        logic                    dirty;
        logic [NUM_PORTS-1:0]    data_available;
        logic [PORT_IDX_W-1:0]   first_responder;
    } snoop_cmd_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } cd_beat_t;

    // resp[3] is shared, resp[2] is dirty
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [3:0]        resp;
        logic              last;
    } r_beat_t;

endpackage

`default_nettype wire

/* verilog/snoop_resp_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module snoop_resp_fsm import snoop_pkg::*; (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire snoop_cmd_t            su_cmd_i,
    input  wire logic                  su_valid_i,
    output logic                       su_ready_o,
    input  wire logic                  fifo_empty_i,
    input  wire logic [DATA_W-1:0]     fifo_data_i,
    input  wire logic [BEAT_IDX_W-1:0] beat_idx_i,
    input  wire logic                  all_last_i,
    output r_beat_t                    r_o,
    output logic                       r_valid_o,
    input  wire logic                  r_ready_i,
    output logic                       pop_o,
    output logic                       start_o,
    output logic                       busy_o,
    output logic                       done_o,
    output snoop_cmd_t                 cmd_q_o
);

    typedef enum logic [1:0] {
        IDLE,
        SEND_BEATS,
        WAIT_R_READY,
        WAIT_CD_LAST
    } state_e;

    state_e     state_q;
    state_e     state_d;
    snoop_cmd_t cmd_q;
    logic       line_end;

    assign line_end = (beat_idx_i == BEAT_IDX_W'(LINE_BEATS - 1));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            cmd_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE && su_valid_i) begin
                cmd_q <= su_cmd_i;
            end
        end
    end

    always_comb begin
        state_d    = state_q;
        su_ready_o = 1'b0;
        r_o        = '0;
        r_valid_o  = 1'b0;
        pop_o      = 1'b0;
        start_o    = 1'b0;
        done_o     = 1'b0;

        case (state_q)
            IDLE: begin
                su_ready_o = 1'b1;
                if (su_valid_i) begin
                    if (su_cmd_i.op == SEND_INVALID_ACK_R) begin
                        // Empty ack goes out in the handshake cycle
                        r_o.id    = su_cmd_i.id;
                        r_o.last  = 1'b1;
                        r_valid_o = 1'b1;
                        if (!r_ready_i) state_d = WAIT_R_READY;
                    end else begin
                        start_o = 1'b1;
                        state_d = SEND_BEATS;
                    end
                end
            end

            SEND_BEATS: begin
                r_o.id   = cmd_q.id;
                r_o.data = fifo_data_i;
                r_o.resp = {cmd_q.shared, cmd_q.dirty, 2'b00};
                if (!fifo_empty_i) begin
                    if (cmd_q.single_beat && beat_idx_i != cmd_q.beat_offset) begin
                        pop_o = 1'b1;  // Not the addressed beat, drop it
                    end else begin
                        r_o.last  = cmd_q.single_beat || line_end;
                        r_valid_o = 1'b1;
                        if (r_ready_i) begin
                            pop_o = 1'b1;
                            if (r_o.last) begin
                                if (all_last_i) begin
                                    done_o  = 1'b1;
                                    state_d = IDLE;
                                end else begin
                                    state_d = WAIT_CD_LAST;
                                end
                            end
                        end
                    end
                end
            end

            WAIT_R_READY: begin
                r_o.id    = cmd_q.id;
                r_o.last  = 1'b1;
                r_valid_o = 1'b1;
                if (r_ready_i) state_d = IDLE;
            end

            WAIT_CD_LAST: begin
                // Leftover first-responder beats are discarded so the port can finish
                pop_o = !fifo_empty_i;
                if (all_last_i) begin
                    done_o  = 1'b1;
                    state_d = IDLE;
                end
            end

            default: state_d = IDLE;
        endcase
    end

    assign busy_o  = (state_q == SEND_BEATS) || (state_q == WAIT_CD_LAST);
    assign cmd_q_o = cmd_q;

endmodule

`default_nettype wire

/* verilog/snoop_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module snoop_unit_top import snoop_pkg::*; (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire snoop_cmd_t           su_cmd_i,
    input  wire logic                 su_valid_i,
    output logic                      su_ready_o,
    input  wire cd_beat_t [NUM_PORTS-1:0] cd_i,
    input  wire logic [NUM_PORTS-1:0] cd_valid_i,
    output logic      [NUM_PORTS-1:0] cd_ready_o,
    output r_beat_t                   r_o,
    output logic                      r_valid_o,
    input  wire logic                 r_ready_i,
    output logic                      cd_busy_o,
    output logic                      cd_done_o
);

    logic                  busy;
    logic                  start;
    logic                  pop;
    logic                  push;
    logic [DATA_W-1:0]     push_data;
    logic [DATA_W-1:0]     fifo_data;
    logic                  fifo_full;
    logic                  fifo_empty;
    logic                  fifo_flush;
    logic [BEAT_IDX_W-1:0] beat_idx;
    logic                  all_last;
    snoop_cmd_t            cmd_q;

    assign fifo_flush = !busy;  // Buffer starts empty for every read
    assign cd_busy_o  = busy;

    snoop_resp_fsm fsm0 (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .su_cmd_i     (su_cmd_i),
        .su_valid_i   (su_valid_i),
        .su_ready_o   (su_ready_o),
        .fifo_empty_i (fifo_empty),
        .fifo_data_i  (fifo_data),
        .beat_idx_i   (beat_idx),
        .all_last_i   (all_last),
        .r_o          (r_o),
        .r_valid_o    (r_valid_o),
        .r_ready_i    (r_ready_i),
        .pop_o        (pop),
        .start_o      (start),
        .busy_o       (busy),
        .done_o       (cd_done_o),
        .cmd_q_o      (cmd_q)
    );

    beat_counter cnt0 (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .clear_i    (start),
        .incr_i     (pop),
        .beat_idx_o (beat_idx)
    );

    cd_collector col0 (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .busy_i            (busy),
        .data_available_i  (cmd_q.data_available),
        .first_responder_i (cmd_q.first_responder),
        .fifo_full_i       (fifo_full),
        .cd_i              (cd_i),
        .cd_valid_i        (cd_valid_i),
        .cd_ready_o        (cd_ready_o),
        .push_o            (push),
        .push_data_o       (push_data),
        .all_last_o        (all_last)
    );

    snoop_data_fifo fifo0 (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (fifo_flush),
        .push_i  (push),
        .pop_i   (pop),
        .data_i  (push_data),
        .data_o  (fifo_data),
        .full_o  (fifo_full),
        .empty_o (fifo_empty)
    );

endmodule

`default_nettype wire
